// ==== rtl/fpu_pkg.sv ====
package fpu_pkg;

	localparam int ROB_WIDTH    = 4;
	localparam int WORD_WIDTH   = 32;
	localparam int EXP_WIDTH    = 8;
	localparam int FRAC_WIDTH   = 23;
	localparam int XEXP_WIDTH   = EXP_WIDTH + 2;
	// hidden bit, fraction, then guard, round and sticky
	localparam int SIG_WIDTH    = FRAC_WIDTH + 4;
	localparam int CREDIT_WIDTH = 3;

	localparam int N_ENTRY        = 2;
	localparam int RESULT_CREDITS = 4;

	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;

	typedef logic [ROB_WIDTH-1:0]    tag_t;
	typedef logic [WORD_WIDTH-1:0]   word_t;
	typedef logic [XEXP_WIDTH-1:0]   exp_t;
	typedef logic [SIG_WIDTH-1:0]    sig_t;
	// one extra bit on top for the carry out of the significand adder
	typedef logic [SIG_WIDTH:0]      sum_t;
	typedef logic [CREDIT_WIDTH-1:0] credit_t;

	localparam word_t QNAN = 32'h7fc0_0000;

endpackage

// ==== rtl/fadd_rs.sv ====
module fadd_rs (
	input  logic            clk,
	input  logic            reset,
	input  logic            issue_valid,
	input  fpu_pkg::tag_t   issue_tag,
	input  logic            issue_sub,
	input  logic            opa_ready,
	input  fpu_pkg::tag_t   opa_tag,
	input  fpu_pkg::word_t  opa_data,
	input  logic            opb_ready,
	input  fpu_pkg::tag_t   opb_tag,
	input  fpu_pkg::word_t  opb_data,
	input  logic            cdb_valid,
	input  fpu_pkg::tag_t   cdb_tag,
	input  fpu_pkg::word_t  cdb_data,
	input  logic            result_credit,
	output logic            issue_ready,
	output logic            disp_valid,
	output fpu_pkg::tag_t   disp_tag,
	output logic            disp_sub,
	output fpu_pkg::word_t  disp_a,
	output fpu_pkg::word_t  disp_b
);
	localparam int NEW_IDX   = fpu_pkg::N_ENTRY;
	localparam int EMPTY_IDX = fpu_pkg::N_ENTRY + 1;
	localparam int N_CAND    = fpu_pkg::N_ENTRY + 2;
	localparam int SRC_WIDTH = $clog2(N_CAND);

	// entries stay packed from slot 0, so slot 0 always holds the oldest
	logic           e_valid  [fpu_pkg::N_ENTRY];
	fpu_pkg::tag_t  e_tag    [fpu_pkg::N_ENTRY];
	logic           e_sub    [fpu_pkg::N_ENTRY];
	logic           e_a_rdy  [fpu_pkg::N_ENTRY];
	fpu_pkg::tag_t  e_a_tag  [fpu_pkg::N_ENTRY];
	fpu_pkg::word_t e_a_data [fpu_pkg::N_ENTRY];
	logic           e_b_rdy  [fpu_pkg::N_ENTRY];
	fpu_pkg::tag_t  e_b_tag  [fpu_pkg::N_ENTRY];
	fpu_pkg::word_t e_b_data [fpu_pkg::N_ENTRY];

	// candidates for the next value of a slot: snooped entries, the new issue, empty
	logic           c_valid  [N_CAND];
	fpu_pkg::tag_t  c_tag    [N_CAND];
	logic           c_sub    [N_CAND];
	logic           c_a_rdy  [N_CAND];
	fpu_pkg::tag_t  c_a_tag  [N_CAND];
	fpu_pkg::word_t c_a_data [N_CAND];
	logic           c_b_rdy  [N_CAND];
	fpu_pkg::tag_t  c_b_tag  [N_CAND];
	fpu_pkg::word_t c_b_data [N_CAND];

	logic [SRC_WIDTH-1:0] src [fpu_pkg::N_ENTRY];
	logic                 complete [fpu_pkg::N_ENTRY];
	logic                 issue_fire;
	logic                 credit_ok;
	logic                 dispatch;
	logic                 disp_sel;
	fpu_pkg::credit_t     credits;

	always_comb begin
		for (int i = 0; i < fpu_pkg::N_ENTRY; i++) begin
			complete[i] = e_valid[i] && e_a_rdy[i] && e_b_rdy[i];
			c_valid[i]  = e_valid[i];
			c_tag[i]    = e_tag[i];
			c_sub[i]    = e_sub[i];
			c_a_rdy[i]  = e_a_rdy[i] || (cdb_valid && cdb_tag == e_a_tag[i]);
			c_a_tag[i]  = e_a_tag[i];
			c_a_data[i] = e_a_rdy[i] ? e_a_data[i] : cdb_data;
			c_b_rdy[i]  = e_b_rdy[i] || (cdb_valid && cdb_tag == e_b_tag[i]);
			c_b_tag[i]  = e_b_tag[i];
			c_b_data[i] = e_b_rdy[i] ? e_b_data[i] : cdb_data;
		end
		// an issuing operand can pick up the broadcast of this same cycle
		c_valid[NEW_IDX]  = issue_fire;
		c_tag[NEW_IDX]    = issue_tag;
		c_sub[NEW_IDX]    = issue_sub;
		c_a_rdy[NEW_IDX]  = opa_ready || (cdb_valid && cdb_tag == opa_tag);
		c_a_tag[NEW_IDX]  = opa_tag;
		c_a_data[NEW_IDX] = opa_ready ? opa_data : cdb_data;
		c_b_rdy[NEW_IDX]  = opb_ready || (cdb_valid && cdb_tag == opb_tag);
		c_b_tag[NEW_IDX]  = opb_tag;
		c_b_data[NEW_IDX] = opb_ready ? opb_data : cdb_data;

		c_valid[EMPTY_IDX]  = 1'b0;
		c_tag[EMPTY_IDX]    = '0;
		c_sub[EMPTY_IDX]    = 1'b0;
		c_a_rdy[EMPTY_IDX]  = 1'b0;
		c_a_tag[EMPTY_IDX]  = '0;
		c_a_data[EMPTY_IDX] = '0;
		c_b_rdy[EMPTY_IDX]  = 1'b0;
		c_b_tag[EMPTY_IDX]  = '0;
		c_b_data[EMPTY_IDX] = '0;
	end

	// a credit coming back this cycle can be spent by this cycle's dispatch
	assign credit_ok   = credits != '0 || result_credit;
	assign dispatch    = (complete[0] || complete[1]) && credit_ok;
	assign disp_sel    = !complete[0];
	assign issue_ready = dispatch || !e_valid[fpu_pkg::N_ENTRY-1];
	assign issue_fire  = issue_valid && issue_ready;

	always_comb begin
		if (dispatch && !disp_sel) begin
			src[0] = e_valid[1] ? SRC_WIDTH'(1) : SRC_WIDTH'(NEW_IDX);
			src[1] = e_valid[1] ? SRC_WIDTH'(NEW_IDX) : SRC_WIDTH'(EMPTY_IDX);
		end else if (dispatch) begin
			src[0] = SRC_WIDTH'(0);
			src[1] = SRC_WIDTH'(NEW_IDX);
		end else begin
			src[0] = e_valid[0] ? SRC_WIDTH'(0) : SRC_WIDTH'(NEW_IDX);
			if (e_valid[1])
				src[1] = SRC_WIDTH'(1);
			else
				src[1] = e_valid[0] ? SRC_WIDTH'(NEW_IDX) : SRC_WIDTH'(EMPTY_IDX);
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < fpu_pkg::N_ENTRY; s++) begin
			if (reset)
				e_valid[s] <= 1'b0;
			else
				e_valid[s] <= c_valid[src[s]];
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < fpu_pkg::N_ENTRY; s++) begin
			e_tag[s]    <= c_tag[src[s]];
			e_sub[s]    <= c_sub[src[s]];
			e_a_rdy[s]  <= c_a_rdy[src[s]];
			e_a_tag[s]  <= c_a_tag[src[s]];
			e_a_data[s] <= c_a_data[src[s]];
			e_b_rdy[s]  <= c_b_rdy[src[s]];
			e_b_tag[s]  <= c_b_tag[src[s]];
			e_b_data[s] <= c_b_data[src[s]];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			disp_valid <= 1'b0;
			credits    <= fpu_pkg::credit_t'(fpu_pkg::RESULT_CREDITS);
		end else begin
			disp_valid <= dispatch;
			credits    <= credits + fpu_pkg::credit_t'(result_credit)
			              - fpu_pkg::credit_t'(dispatch);
		end
	end

	always_ff @(posedge clk) begin
		disp_tag <= e_tag[disp_sel];
		disp_sub <= e_sub[disp_sel];
		disp_a   <= e_a_data[disp_sel];
		disp_b   <= e_b_data[disp_sel];
	end

endmodule

// ==== rtl/fadd_align.sv ====
module fadd_align (
	input  logic            clk,
	input  logic            reset,
	input  logic            disp_valid,
	input  fpu_pkg::tag_t   disp_tag,
	input  logic            disp_sub,
	input  fpu_pkg::word_t  disp_a,
	input  fpu_pkg::word_t  disp_b,
	output logic            al_valid,
	output fpu_pkg::tag_t   al_tag,
	output logic            al_sign_big,
	output logic            al_eff_sub,
	output fpu_pkg::exp_t   al_exp,
	output fpu_pkg::sig_t   al_sig_big,
	output fpu_pkg::sig_t   al_sig_small,
	output logic            al_special,
	output fpu_pkg::word_t  al_special_val
);
	logic                            sign_a;
	logic                            sign_b;
	logic [fpu_pkg::EXP_WIDTH-1:0]   exp_a;
	logic [fpu_pkg::EXP_WIDTH-1:0]   exp_b;
	logic [fpu_pkg::FRAC_WIDTH-1:0]  frac_a;
	logic [fpu_pkg::FRAC_WIDTH-1:0]  frac_b;
	logic                            nan_a;
	logic                            nan_b;
	logic                            inf_a;
	logic                            inf_b;
	fpu_pkg::sig_t                   sig_a;
	fpu_pkg::sig_t                   sig_b;
	logic                            swap;
	logic                            sign_big;
	logic [fpu_pkg::EXP_WIDTH-1:0]   exp_big;
	logic [fpu_pkg::EXP_WIDTH-1:0]   exp_small;
	logic [fpu_pkg::EXP_WIDTH-1:0]   exp_diff;
	fpu_pkg::sig_t                   sig_big;
	fpu_pkg::sig_t                   sig_small;
	fpu_pkg::sig_t                   shifted;
	fpu_pkg::sig_t                   lost_mask;
	logic                            sticky;
	logic                            special;
	fpu_pkg::word_t                  special_val;

	always_comb begin
		sign_a = disp_a[fpu_pkg::WORD_WIDTH-1];
		exp_a  = disp_a[fpu_pkg::WORD_WIDTH-2:fpu_pkg::FRAC_WIDTH];
		frac_a = disp_a[fpu_pkg::FRAC_WIDTH-1:0];
		// a subtraction is an addition of b with its sign flipped
		sign_b = disp_b[fpu_pkg::WORD_WIDTH-1] ^ disp_sub;
		exp_b  = disp_b[fpu_pkg::WORD_WIDTH-2:fpu_pkg::FRAC_WIDTH];
		frac_b = disp_b[fpu_pkg::FRAC_WIDTH-1:0];

		nan_a = exp_a == fpu_pkg::EXP_MAX && frac_a != '0;
		nan_b = exp_b == fpu_pkg::EXP_MAX && frac_b != '0;
		inf_a = exp_a == fpu_pkg::EXP_MAX && frac_a == '0;
		inf_b = exp_b == fpu_pkg::EXP_MAX && frac_b == '0;

		// zero exponent means zero or subnormal, both become a signed zero
		sig_a = (exp_a == '0) ? '0 : {1'b1, frac_a, 3'b000};
		sig_b = (exp_b == '0) ? '0 : {1'b1, frac_b, 3'b000};

		swap      = {exp_b, frac_b} > {exp_a, frac_a};
		sign_big  = swap ? sign_b : sign_a;
		exp_big   = swap ? exp_b : exp_a;
		exp_small = swap ? exp_a : exp_b;
		sig_big   = swap ? sig_b : sig_a;
		sig_small = swap ? sig_a : sig_b;

		// shifts past the width clear the mask term, so everything lands in sticky
		exp_diff  = exp_big - exp_small;
		shifted   = sig_small >> exp_diff;
		lost_mask = (fpu_pkg::sig_t'(1) << exp_diff) - fpu_pkg::sig_t'(1);
		sticky    = |(sig_small & lost_mask);

		special = nan_a || nan_b || inf_a || inf_b;
		if (nan_a || nan_b || (inf_a && inf_b && sign_a != sign_b))
			special_val = fpu_pkg::QNAN;
		else if (inf_a)
			special_val = {sign_a, disp_a[fpu_pkg::WORD_WIDTH-2:0]};
		else
			special_val = {sign_b, disp_b[fpu_pkg::WORD_WIDTH-2:0]};
	end

	always_ff @(posedge clk) begin
		if (reset)
			al_valid <= 1'b0;
		else
			al_valid <= disp_valid;
	end

	always_ff @(posedge clk) begin
		al_tag         <= disp_tag;
		al_sign_big    <= sign_big;
		al_eff_sub     <= sign_a ^ sign_b;
		al_exp         <= fpu_pkg::exp_t'(exp_big);
		al_sig_big     <= sig_big;
		al_sig_small   <= {shifted[fpu_pkg::SIG_WIDTH-1:1], shifted[0] | sticky};
		al_special     <= special;
		al_special_val <= special_val;
	end

endmodule

// ==== rtl/fadd_sum.sv ====
module fadd_sum (
	input  logic            clk,
	input  logic            reset,
	input  logic            al_valid,
	input  fpu_pkg::tag_t   al_tag,
	input  logic            al_sign_big,
	input  logic            al_eff_sub,
	input  fpu_pkg::exp_t   al_exp,
	input  fpu_pkg::sig_t   al_sig_big,
	input  fpu_pkg::sig_t   al_sig_small,
	input  logic            al_special,
	input  fpu_pkg::word_t  al_special_val,
	output logic            sm_valid,
	output fpu_pkg::tag_t   sm_tag,
	output logic            sm_sign,
	output fpu_pkg::exp_t   sm_exp,
	output fpu_pkg::sum_t   sm_sum,
	output logic            sm_zero,
	output logic            sm_special,
	output fpu_pkg::word_t  sm_special_val
);
	fpu_pkg::sum_t sum;
	logic          zero;

	// the big operand never has the smaller magnitude, so the difference stays positive
	always_comb begin
		if (al_eff_sub)
			sum = {1'b0, al_sig_big} - {1'b0, al_sig_small};
		else
			sum = {1'b0, al_sig_big} + {1'b0, al_sig_small};
		zero = sum == '0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			sm_valid <= 1'b0;
		else
			sm_valid <= al_valid;
	end

	always_ff @(posedge clk) begin
		sm_tag         <= al_tag;
		// cancellation gives +0, while a same-sign zero sum keeps the common sign
		sm_sign        <= (zero && al_eff_sub) ? 1'b0 : al_sign_big;
		sm_exp         <= al_exp;
		sm_sum         <= sum;
		sm_zero        <= zero;
		sm_special     <= al_special;
		sm_special_val <= al_special_val;
	end

endmodule

// ==== rtl/fadd_norm.sv ====
module fadd_norm (
	input  logic            clk,
	input  logic            reset,
	input  logic            sm_valid,
	input  fpu_pkg::tag_t   sm_tag,
	input  logic            sm_sign,
	input  fpu_pkg::exp_t   sm_exp,
	input  fpu_pkg::sum_t   sm_sum,
	input  logic            sm_zero,
	input  logic            sm_special,
	input  fpu_pkg::word_t  sm_special_val,
	output logic            result_valid,
	output fpu_pkg::tag_t   result_tag,
	output fpu_pkg::word_t  result_data
);
	localparam int LZ_WIDTH  = $clog2(fpu_pkg::SIG_WIDTH + 1);
	localparam int RND_WIDTH = fpu_pkg::FRAC_WIDTH + 2;

	logic [LZ_WIDTH-1:0]             lz;
	fpu_pkg::sig_t                   norm_sig;
	fpu_pkg::exp_t                   norm_exp;
	fpu_pkg::exp_t                   rnd_exp;
	logic                            guard;
	logic                            round_bit;
	logic                            sticky;
	logic                            round_up;
	logic [RND_WIDTH-1:0]            rnd_sig;
	logic [fpu_pkg::FRAC_WIDTH-1:0]  frac_out;
	logic                            underflow;
	logic                            overflow;
	fpu_pkg::word_t                  word_out;

	function automatic logic [LZ_WIDTH-1:0] lead_zeros(input fpu_pkg::sig_t v);
		logic [LZ_WIDTH-1:0] n;
		logic                found;
		n = '0;
		found = 1'b0;
		for (int i = fpu_pkg::SIG_WIDTH - 1; i >= 0; i--) begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 1'b1;
		end
		return n;
	endfunction

	always_comb begin
		lz = lead_zeros(sm_sum[fpu_pkg::SIG_WIDTH-1:0]);
		if (sm_sum[fpu_pkg::SIG_WIDTH]) begin
			// carry out, so one bit drops into sticky
			norm_sig = {sm_sum[fpu_pkg::SIG_WIDTH:2], sm_sum[1] | sm_sum[0]};
			norm_exp = sm_exp + 1'b1;
		end else begin
			norm_sig = sm_sum[fpu_pkg::SIG_WIDTH-1:0] << lz;
			norm_exp = sm_exp - fpu_pkg::exp_t'(lz);
		end
		// the top exponent bit is set when the left shift went below zero
		underflow = norm_exp[fpu_pkg::XEXP_WIDTH-1] || norm_exp == '0;

		guard     = norm_sig[2];
		round_bit = norm_sig[1];
		sticky    = norm_sig[0];
		round_up  = guard && (round_bit || sticky || norm_sig[3]);
		rnd_sig   = {1'b0, norm_sig[fpu_pkg::SIG_WIDTH-1:3]} + RND_WIDTH'(round_up);

		if (rnd_sig[RND_WIDTH-1]) begin
			frac_out = rnd_sig[fpu_pkg::FRAC_WIDTH:1];
			rnd_exp  = norm_exp + 1'b1;
		end else begin
			frac_out = rnd_sig[fpu_pkg::FRAC_WIDTH-1:0];
			rnd_exp  = norm_exp;
		end
		overflow = !underflow && rnd_exp >= fpu_pkg::EXP_MAX;

		if (sm_special)
			word_out = sm_special_val;
		else if (sm_zero || underflow)
			word_out = {sm_sign, {(fpu_pkg::WORD_WIDTH-1){1'b0}}};
		else if (overflow)
			word_out = {sm_sign, {fpu_pkg::EXP_WIDTH{1'b1}}, {fpu_pkg::FRAC_WIDTH{1'b0}}};
		else
			word_out = {sm_sign, rnd_exp[fpu_pkg::EXP_WIDTH-1:0], frac_out};
	end

	always_ff @(posedge clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= sm_valid;
	end

	always_ff @(posedge clk) begin
		result_tag  <= sm_tag;
		result_data <= word_out;
	end

endmodule

// ==== rtl/fadd_unit.sv ====
module fadd_unit (
	input  logic            clk,
	input  logic            reset,
	input  logic            issue_valid,
	input  fpu_pkg::tag_t   issue_tag,
	input  logic            issue_sub,
	input  logic            opa_ready,
	input  fpu_pkg::tag_t   opa_tag,
	input  fpu_pkg::word_t  opa_data,
	input  logic            opb_ready,
	input  fpu_pkg::tag_t   opb_tag,
	input  fpu_pkg::word_t  opb_data,
	input  logic            cdb_valid,
	input  fpu_pkg::tag_t   cdb_tag,
	input  fpu_pkg::word_t  cdb_data,
	input  logic            result_credit,
	output logic            issue_ready,
	output logic            result_valid,
	output fpu_pkg::tag_t   result_tag,
	output fpu_pkg::word_t  result_data
);
	logic           disp_valid;
	fpu_pkg::tag_t  disp_tag;
	logic           disp_sub;
	fpu_pkg::word_t disp_a;
	fpu_pkg::word_t disp_b;

	logic           al_valid;
	fpu_pkg::tag_t  al_tag;
	logic           al_sign_big;
	logic           al_eff_sub;
	fpu_pkg::exp_t  al_exp;
	fpu_pkg::sig_t  al_sig_big;
	fpu_pkg::sig_t  al_sig_small;
	logic           al_special;
	fpu_pkg::word_t al_special_val;

	logic           sm_valid;
	fpu_pkg::tag_t  sm_tag;
	logic           sm_sign;
	fpu_pkg::exp_t  sm_exp;
	fpu_pkg::sum_t  sm_sum;
	logic           sm_zero;
	logic           sm_special;
	fpu_pkg::word_t sm_special_val;

	fadd_rs u_rs (
		.clk           (clk),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.issue_tag     (issue_tag),
		.issue_sub     (issue_sub),
		.opa_ready     (opa_ready),
		.opa_tag       (opa_tag),
		.opa_data      (opa_data),
		.opb_ready     (opb_ready),
		.opb_tag       (opb_tag),
		.opb_data      (opb_data),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_data      (cdb_data),
		.result_credit (result_credit),
		.issue_ready   (issue_ready),
		.disp_valid    (disp_valid),
		.disp_tag      (disp_tag),
		.disp_sub      (disp_sub),
		.disp_a        (disp_a),
		.disp_b        (disp_b)
	);

	fadd_align u_align (
		.clk            (clk),
		.reset          (reset),
		.disp_valid     (disp_valid),
		.disp_tag       (disp_tag),
		.disp_sub       (disp_sub),
		.disp_a         (disp_a),
		.disp_b         (disp_b),
		.al_valid       (al_valid),
		.al_tag         (al_tag),
		.al_sign_big    (al_sign_big),
		.al_eff_sub     (al_eff_sub),
		.al_exp         (al_exp),
		.al_sig_big     (al_sig_big),
		.al_sig_small   (al_sig_small),
		.al_special     (al_special),
		.al_special_val (al_special_val)
	);

	fadd_sum u_sum (
		.clk            (clk),
		.reset          (reset),
		.al_valid       (al_valid),
		.al_tag         (al_tag),
		.al_sign_big    (al_sign_big),
		.al_eff_sub     (al_eff_sub),
		.al_exp         (al_exp),
		.al_sig_big     (al_sig_big),
		.al_sig_small   (al_sig_small),
		.al_special     (al_special),
		.al_special_val (al_special_val),
		.sm_valid       (sm_valid),
		.sm_tag         (sm_tag),
		.sm_sign        (sm_sign),
		.sm_exp         (sm_exp),
		.sm_sum         (sm_sum),
		.sm_zero        (sm_zero),
		.sm_special     (sm_special),
		.sm_special_val (sm_special_val)
	);

	fadd_norm u_norm (
		.clk            (clk),
		.reset          (reset),
		.sm_valid       (sm_valid),
		.sm_tag         (sm_tag),
		.sm_sign        (sm_sign),
		.sm_exp         (sm_exp),
		.sm_sum         (sm_sum),
		.sm_zero        (sm_zero),
		.sm_special     (sm_special),
		.sm_special_val (sm_special_val),
		.result_valid   (result_valid),
		.result_tag     (result_tag),
		.result_data    (result_data)
	);

endmodule

// ==== sim/fadd_checker.sv ====
module fadd_checker (
	input  logic            clk,
	input  logic            reset,
	input  logic            issue_valid,
	input  logic            issue_ready,
	input  fpu_pkg::tag_t   issue_tag,
	input  int              row_idx,
	input  fpu_pkg::word_t  row_exp,
	input  logic            result_valid,
	input  fpu_pkg::tag_t   result_tag,
	input  fpu_pkg::word_t  result_data,
	input  logic            result_credit,
	output int              errors,
	output int              results,
	output logic [15:0]     busy
);
	fpu_pkg::word_t exp_by_tag [16];
	int             row_by_tag [16];
	int             granted;

	initial begin
		errors  = 0;
		results = 0;
		busy    = '0;
		granted = fpu_pkg::RESULT_CREDITS;
	end

	always @(posedge clk) begin
		if (reset) begin
			busy    = '0;
			granted = fpu_pkg::RESULT_CREDITS;
		end else begin
			// results retire first so a tag freed this cycle could be issued again
			if (result_valid) begin
				results++;
				if (!busy[result_tag]) begin
					$display("result arrived for tag %0d, which has nothing in flight", result_tag);
					errors++;
				end else begin
					if (result_data !== exp_by_tag[result_tag]) begin
						$display("[FAIL] result_data tag=%h got=%h exp=%h (row %0d)",
						         result_tag, result_data, exp_by_tag[result_tag],
						         row_by_tag[result_tag]);
						errors++;
					end
					busy[result_tag] = 1'b0;
				end
				if (results > granted) begin
					$display("more results came out than credits were granted (%0d > %0d)",
					         results, granted);
					errors++;
				end
			end
			if (result_credit)
				granted++;
			if (issue_valid && issue_ready) begin
				if (busy[issue_tag]) begin
					$display("tag %0d was issued again while still in flight", issue_tag);
					errors++;
				end
				busy[issue_tag]       = 1'b1;
				exp_by_tag[issue_tag] = row_exp;
				row_by_tag[issue_tag] = row_idx;
			end
		end
	end

	task automatic report_missing();
		for (int t = 0; t < 16; t++) begin
			if (busy[t]) begin
				$display("tag %0d from row %0d never produced a result", t, row_by_tag[t]);
				errors++;
			end
		end
	endtask

endmodule

// ==== sim/fadd_unit_tb.sv ====
module fadd_unit_tb;
	localparam int N_ROWS = 27;
	localparam int LIMIT  = 200 * N_ROWS + 500;
	// operand arrival: ready at issue, on the CDB in the issue cycle, or on the CDB later
	localparam logic [1:0] RDY  = 2'd0;
	localparam logic [1:0] SAME = 2'd1;
	localparam logic [1:0] LATE = 2'd2;

	logic           clk = 1'b0;
	logic           reset = 1'b1;
	logic           issue_valid, issue_sub, opa_ready, opb_ready, cdb_valid;
	fpu_pkg::tag_t  issue_tag, opa_tag, opb_tag, cdb_tag;
	fpu_pkg::word_t opa_data, opb_data, cdb_data;
	logic           result_credit = 1'b0;
	logic           issue_ready, result_valid;
	fpu_pkg::tag_t  result_tag;
	fpu_pkg::word_t result_data;
	int             row_idx;
	fpu_pkg::word_t row_exp;
	int             chk_errors, results;
	logic [15:0]    busy;

	int             tb_errors = 0;
	int             cycle = 0;
	int             n_rows = 0;
	int             pool = 0;
	int             owed = 0;
	int             gap = 0;
	bit             hold_credits = 1'b1;
	logic           t_sub [N_ROWS];
	fpu_pkg::word_t t_a [N_ROWS];
	fpu_pkg::word_t t_b [N_ROWS];
	fpu_pkg::word_t t_exp [N_ROWS];
	logic [1:0]     t_wa [N_ROWS];
	logic [1:0]     t_wb [N_ROWS];
	int             q_due [$];
	fpu_pkg::tag_t  q_tag [$];
	fpu_pkg::word_t q_data [$];

	fadd_unit u_dut (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_tag(issue_tag),
		.issue_sub(issue_sub), .opa_ready(opa_ready), .opa_tag(opa_tag), .opa_data(opa_data),
		.opb_ready(opb_ready), .opb_tag(opb_tag), .opb_data(opb_data),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.result_credit(result_credit), .issue_ready(issue_ready),
		.result_valid(result_valid), .result_tag(result_tag), .result_data(result_data)
	);

	fadd_checker u_chk (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_ready(issue_ready),
		.issue_tag(issue_tag), .row_idx(row_idx), .row_exp(row_exp),
		.result_valid(result_valid), .result_tag(result_tag), .result_data(result_data),
		.result_credit(result_credit), .errors(chk_errors), .results(results), .busy(busy)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle++;
		if (cycle >= LIMIT) begin
			$display("timeout after %0d cycles with %0d results seen", cycle, results);
			$display("errors: testbench=%0d checker=%0d", tb_errors, chk_errors);
			$display("TB FAILED");
			$finish;
		end
	end

	// returns one credit per result, with random gaps, unless credits are held back
	always @(negedge clk) begin
		result_credit = 1'b0;
		if (!reset) begin
			if (result_valid)
				owed++;
			if (gap > 0)
				gap--;
			else if (!hold_credits && owed > 0) begin
				result_credit = 1'b1;
				owed--;
				gap = $urandom % 3;
			end
		end
	end

	task automatic add_row(input logic sub, input fpu_pkg::word_t a, input logic [1:0] wa,
	                       input fpu_pkg::word_t b, input logic [1:0] wb,
	                       input fpu_pkg::word_t exp);
		t_sub[n_rows] = sub;
		t_a[n_rows]   = a;
		t_wa[n_rows]  = wa;
		t_b[n_rows]   = b;
		t_wb[n_rows]  = wb;
		t_exp[n_rows] = exp;
		n_rows++;
	endtask

	// one falling edge: the same-cycle bypass wins the CDB, otherwise the first due broadcast
	task automatic next_cycle(input logic bypass, input fpu_pkg::tag_t btag,
	                          input fpu_pkg::word_t bdata);
		int pick;
		pick = -1;
		@(negedge clk);
		issue_valid = 1'b0;
		for (int i = 0; i < q_due.size(); i++)
			if (pick < 0 && q_due[i] <= cycle)
				pick = i;
		if (bypass) begin
			cdb_valid = 1'b1;
			cdb_tag   = btag;
			cdb_data  = bdata;
		end else if (pick >= 0) begin
			cdb_valid = 1'b1;
			cdb_tag   = q_tag[pick];
			cdb_data  = q_data[pick];
			q_due.delete(pick);
			q_tag.delete(pick);
			q_data.delete(pick);
		end else
			cdb_valid = 1'b0;
	endtask

	task automatic issue_row(input int r);
		fpu_pkg::tag_t  tag;
		fpu_pkg::tag_t  pa;
		fpu_pkg::tag_t  pb;
		logic           byp;
		logic           fired;
		tag = fpu_pkg::tag_t'(r % 8);
		pa  = '0;
		pb  = '0;
		// producer tags come from the upper half, issue tags from the lower half
		if (t_wa[r] != RDY) begin
			pa = fpu_pkg::tag_t'(8 + pool % 8);
			pool++;
		end
		if (t_wb[r] != RDY) begin
			pb = fpu_pkg::tag_t'(8 + pool % 8);
			pool++;
		end
		byp = t_wa[r] == SAME || t_wb[r] == SAME;
		while (busy[tag])
			next_cycle(1'b0, '0, '0);
		// the station must have room first, or the bypass would keep the queued broadcasts
		// off the CDB while both entries wait on them
		if (byp) begin
			next_cycle(1'b0, '0, '0);
			#1;
			while (!issue_ready) begin
				next_cycle(1'b0, '0, '0);
				#1;
			end
		end
		fired = 1'b0;
		while (!fired) begin
			next_cycle(byp, (t_wa[r] == SAME) ? pa : pb, (t_wa[r] == SAME) ? t_a[r] : t_b[r]);
			issue_valid = 1'b1;
			issue_tag   = tag;
			issue_sub   = t_sub[r];
			opa_ready   = t_wa[r] == RDY;
			opa_tag     = pa;
			opa_data    = opa_ready ? t_a[r] : 32'hdead_beef;
			opb_ready   = t_wb[r] == RDY;
			opb_tag     = pb;
			opb_data    = opb_ready ? t_b[r] : 32'hdead_beef;
			row_idx     = r;
			row_exp     = t_exp[r];
			#1;
			fired = issue_ready;
		end
		if (t_wa[r] == LATE) begin
			q_due.push_back(cycle + 1 + $urandom % 6);
			q_tag.push_back(pa);
			q_data.push_back(t_a[r]);
		end
		if (t_wb[r] == LATE) begin
			q_due.push_back(cycle + 1 + $urandom % 6);
			q_tag.push_back(pb);
			q_data.push_back(t_b[r]);
		end
	endtask

	task automatic check_credit_stall();
		repeat (20)
			next_cycle(1'b0, '0, '0);
		#1;
		if (results != fpu_pkg::RESULT_CREDITS) begin
			$display("[FAIL] result count got=%h exp=%h", results, fpu_pkg::RESULT_CREDITS);
			tb_errors++;
		end
		if (issue_ready !== 1'b0) begin
			$display("[FAIL] issue_ready got=%h exp=%h", issue_ready, 1'b0);
			tb_errors++;
		end
		hold_credits = 1'b0;
	endtask

	initial begin
		issue_valid = 1'b0;
		issue_tag   = '0;
		issue_sub   = 1'b0;
		opa_ready   = 1'b0;
		opa_tag     = '0;
		opa_data    = '0;
		opb_ready   = 1'b0;
		opb_tag     = '0;
		opb_data    = '0;
		cdb_valid   = 1'b0;
		cdb_tag     = '0;
		cdb_data    = '0;
		row_idx     = 0;
		row_exp     = '0;
		void'($urandom(32'h273d_22fe));

		add_row(0, 32'h3f80_0000, RDY, 32'h3f80_0000, RDY, 32'h4000_0000);
		add_row(0, 32'h3fc0_0000, RDY, 32'h4020_0000, RDY, 32'h4080_0000);
		add_row(1, 32'h4040_0000, RDY, 32'h3f80_0000, RDY, 32'h4000_0000);
		add_row(0, 32'h3fe0_0000, RDY, 32'h3fe0_0000, RDY, 32'h4060_0000);
		add_row(1, 32'h3f80_0001, RDY, 32'h3f80_0000, RDY, 32'h3400_0000);
		add_row(0, 32'h3f80_0000, RDY, 32'h3380_0000, RDY, 32'h3f80_0000);
		add_row(0, 32'h3f80_0001, RDY, 32'h3380_0000, RDY, 32'h3f80_0002);
		add_row(0, 32'hbf80_0000, RDY, 32'hbf80_0000, RDY, 32'hc000_0000);
		add_row(0, 32'h4000_0000, SAME, 32'h3f80_0000, RDY, 32'h4040_0000);
		add_row(0, 32'h4040_0000, RDY, 32'h4080_0000, LATE, 32'h40e0_0000);
		add_row(1, 32'h3f80_0000, SAME, 32'h4000_0000, LATE, 32'hbf80_0000);
		add_row(0, 32'h4120_0000, LATE, 32'h3f80_0000, RDY, 32'h4130_0000);
		add_row(1, 32'h40a0_0000, RDY, 32'h3f80_0000, SAME, 32'h4080_0000);
		add_row(0, 32'h7f80_0001, RDY, 32'h3f80_0000, RDY, 32'h7fc0_0000);
		add_row(1, 32'h7f80_0000, RDY, 32'h7f80_0000, RDY, 32'h7fc0_0000);
		add_row(0, 32'h7f80_0000, RDY, 32'h3f80_0000, RDY, 32'h7f80_0000);
		add_row(1, 32'h3f80_0000, RDY, 32'h7f80_0000, LATE, 32'hff80_0000);
		add_row(0, 32'h0000_0001, RDY, 32'h3f80_0000, RDY, 32'h3f80_0000);
		add_row(0, 32'h0040_0000, RDY, 32'h0040_0000, RDY, 32'h0000_0000);
		add_row(0, 32'h8000_0000, RDY, 32'h8000_0000, RDY, 32'h8000_0000);
		add_row(0, 32'h0000_0000, RDY, 32'h8000_0000, RDY, 32'h0000_0000);
		add_row(1, 32'h3f80_0000, LATE, 32'h3f80_0000, RDY, 32'h0000_0000);
		add_row(0, 32'h7f7f_ffff, RDY, 32'h7f7f_ffff, RDY, 32'h7f80_0000);
		add_row(1, 32'h8000_0000, RDY, 32'h0000_0000, RDY, 32'h8000_0000);
		add_row(0, 32'hff7f_ffff, RDY, 32'hff7f_ffff, RDY, 32'hff80_0000);
		add_row(1, 32'h0080_0001, RDY, 32'h0080_0000, RDY, 32'h0000_0000);
		add_row(0, 32'h3fc0_0000, RDY, 32'h4b80_0000, RDY, 32'h4b80_0001);
		if (n_rows != N_ROWS) begin
			$display("stimulus table holds %0d rows instead of %0d", n_rows, N_ROWS);
			tb_errors++;
		end

		repeat (8)
			@(negedge clk);
		reset = 1'b0;
		next_cycle(1'b0, '0, '0);
		#1;
		if (result_valid !== 1'b0) begin
			$display("[FAIL] result_valid got=%h exp=%h", result_valid, 1'b0);
			tb_errors++;
		end
		if (issue_ready !== 1'b1) begin
			$display("[FAIL] issue_ready got=%h exp=%h", issue_ready, 1'b1);
			tb_errors++;
		end

		// the first six rows fill the credits and then both station entries
		for (int r = 0; r < N_ROWS; r++) begin
			if (r == 6)
				check_credit_stall();
			issue_row(r);
		end
		while (results < N_ROWS)
			next_cycle(1'b0, '0, '0);
		repeat (10)
			next_cycle(1'b0, '0, '0);
		u_chk.report_missing();

		$display("errors: testbench=%0d checker=%0d results=%0d", tb_errors, chk_errors, results);
		if (tb_errors == 0 && chk_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
rtl/fpu_pkg.sv
rtl/fadd_rs.sv
rtl/fadd_align.sv
rtl/fadd_sum.sv
rtl/fadd_norm.sv
rtl/fadd_unit.sv
sim/fadd_checker.sv
sim/fadd_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fadd_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fadd_unit_tb -f compile.f -o fadd_sim

out=$(./obj_dir/fadd_sim)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
	exit 0
else
	exit 1
fi
